/* common/fat_defs.svh */
/*
 * FAT16 on-disk constants shared by the reader RTL.
 * Include wherever sector, signature or chain-marker values are needed.
 */
`ifndef FAT_DEFS_SVH
`define FAT_DEFS_SVH

// bytes per sector, the only size the BPB check accepts
`define SECTOR_BYTES 512

// boot signature as read from offsets 1FE and 1FF
`define BOOT_SIG 16'h55AA

// size of one short-name directory entry
`define DIR_ENTRY_BYTES 32

// lowest end-of-chain value, entries below 2 end the chain as well
`define FAT16_EOC_MIN 16'hFFF0

// space padded 8.3 name, 8 name chars plus 3 extension chars
`define NAME_LEN 11

`endif

/* common/fat_pkg.sv */
/*
 * Types shared by the FAT16 file reader.
 * Referenced by scoped name from the RTL modules.
 */
package fat_pkg;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        SEARCH_MBR = 3'd1,
        SEARCH_DBR = 3'd2,
        LS_ROOT    = 3'd3,
        READ_FILE  = 3'd4,
        DONE       = 3'd5
    } fat_state_t;

    // geometry derived from the accepted boot record
    typedef struct packed {
        logic [7:0]  cluster_size;       // sectors per cluster
        logic [31:0] first_fat_sector;
        logic [31:0] root_sector;
        logic [15:0] root_sector_count;
        logic [31:0] first_data_sector;  // already offset by two clusters
    } volume_info_t;

    typedef struct packed {
        logic        hit;
        logic [15:0] first_cluster;
        logic [31:0] file_size;
    } dir_hit_t;

endpackage

/* common/sector_bus_if.sv */
/*
 * Sector read channel inside the reader: one request in flight, bytes
 * returned in address order, then a done pulse.
 */
`timescale 1ns/1ps

interface sector_bus_if;
    logic        start;   // one cycle request pulse
    logic [31:0] sector;  // held until done
    logic        valid;
    logic [8:0]  addr;
    logic [7:0]  data;
    logic        done;

    modport sequencer (
        output start,
        output sector,
        input  valid,
        input  addr,
        input  data,
        input  done
    );

    modport observer (
        input valid,
        input addr,
        input data,
        input done
    );
endinterface

/* hdl/volume_parser.sv */
/*
 * Picks the MBR/DBR fields out of a streamed boot sector and derives the
 * FAT16 volume geometry. Geometry is latched on each done while enabled.
 */
`timescale 1ns/1ps
`include "fat_defs.svh"

module volume_parser (
    input  logic                  clk,
    input  logic                  rst_n,
    sector_bus_if.observer        bus,
    input  logic                  capture_boot,
    input  logic [31:0]           sector_base,
    output logic                  is_boot,
    output logic                  is_dbr,
    output logic [31:0]           partition_sector,
    output logic                  bpb_ok,
    output fat_pkg::volume_info_t vol
);

    logic [7:0]  jump_byte;
    logic [15:0] sig;
    logic [31:0] part_lba;
    logic [15:0] bytes_per_sec;
    logic [7:0]  sec_per_clus;
    logic [15:0] resv_secs;
    logic [7:0]  num_fats;
    logic [15:0] root_entries;
    logic [15:0] secs_per_fat;

    fat_pkg::volume_info_t geom;

    // only the bytes we need, no sector buffer
    always_ff @(posedge clk) begin
        if (capture_boot && bus.valid) begin
            case (bus.addr)
                9'h000: jump_byte          <= bus.data;
                9'h00B: bytes_per_sec[7:0] <= bus.data;
                9'h00C: bytes_per_sec[15:8] <= bus.data;
                9'h00D: sec_per_clus       <= bus.data;
                9'h00E: resv_secs[7:0]     <= bus.data;
                9'h00F: resv_secs[15:8]    <= bus.data;
                9'h010: num_fats           <= bus.data;
                9'h011: root_entries[7:0]  <= bus.data;
                9'h012: root_entries[15:8] <= bus.data;
                9'h016: secs_per_fat[7:0]  <= bus.data;
                9'h017: secs_per_fat[15:8] <= bus.data;
                9'h1C6: part_lba[7:0]      <= bus.data;
                9'h1C7: part_lba[15:8]     <= bus.data;
                9'h1C8: part_lba[23:16]    <= bus.data;
                9'h1C9: part_lba[31:24]    <= bus.data;
                9'h1FE: sig[15:8]          <= bus.data;
                9'h1FF: sig[7:0]           <= bus.data;
                default: ;
            endcase
        end
    end

    assign is_boot          = (sig == `BOOT_SIG);
    assign is_dbr           = (jump_byte == 8'hEB) || (jump_byte == 8'hE9);
    assign partition_sector = part_lba;
    assign bpb_ok           = (bytes_per_sec == 16'(`SECTOR_BYTES)) && (secs_per_fat != 16'd0);

    always_comb begin
        geom.cluster_size      = sec_per_clus;
        geom.first_fat_sector  = sector_base + 32'(resv_secs);
        geom.root_sector       = geom.first_fat_sector + 32'(secs_per_fat) * 32'(num_fats);
        geom.root_sector_count = 16'(32'(root_entries) * `DIR_ENTRY_BYTES / `SECTOR_BYTES);
        // cluster numbering starts at 2
        geom.first_data_sector = geom.root_sector + 32'(geom.root_sector_count)
                               - 32'(sec_per_clus) * 32'd2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vol <= '0;
        end else if (capture_boot && bus.done) begin
            vol <= geom;  // last capture is the accepted dbr
        end
    end

endmodule

/* hdl/dir_scanner.sv */
/*
 * Walks 32-byte root directory entries as they stream past and flags the
 * first live entry whose 8.3 name equals FILE_NAME, ignoring case.
 */
`timescale 1ns/1ps
`include "fat_defs.svh"

module dir_scanner #(
    parameter logic [8*`NAME_LEN-1:0] FILE_NAME = "readme  txt"
) (
    input  logic              clk,
    input  logic              rst_n,
    sector_bus_if.observer    bus,
    input  logic              scan_dir,
    output fat_pkg::dir_hit_t hit
);

    function automatic logic [7:0] to_upper(input logic [7:0] c);
        return (c >= "a" && c <= "z") ? (c & 8'hDF) : c;
    endfunction

    function automatic logic [8*`NAME_LEN-1:0] upcase_name(input logic [8*`NAME_LEN-1:0] n);
        logic [8*`NAME_LEN-1:0] r;
        for (int i = 0; i < `NAME_LEN; i++) begin
            r[8*i +: 8] = to_upper(n[8*i +: 8]);
        end
        return r;
    endfunction

    localparam logic [8*`NAME_LEN-1:0] TARGET = upcase_name(FILE_NAME);

    logic [7:0]  name_buf [`NAME_LEN];
    logic [7:0]  attr;
    logic [15:0] clus;
    logic [23:0] size_lo;
    logic [4:0]  off;
    logic        name_match;
    logic        entry_ok;

    assign off = bus.addr[4:0];

    always_comb begin
        name_match = 1'b1;
        for (int i = 0; i < `NAME_LEN; i++) begin
            // first char sits in the top byte of the string
            if (to_upper(name_buf[i]) != TARGET[8*(`NAME_LEN-1-i) +: 8]) begin
                name_match = 1'b0;
            end
        end
    end

    // skip deleted and volume label entries
    assign entry_ok = name_match && (name_buf[0] != 8'hE5) && !attr[3];

    always_ff @(posedge clk) begin
        if (scan_dir && bus.valid) begin
            if (off < 5'(`NAME_LEN)) name_buf[off[3:0]] <= bus.data;
            if (off == 5'h0B) attr <= bus.data;
            if (off == 5'h1A) clus[7:0] <= bus.data;
            if (off == 5'h1B) clus[15:8] <= bus.data;
            if (off == 5'h1C) size_lo[7:0] <= bus.data;
            if (off == 5'h1D) size_lo[15:8] <= bus.data;
            if (off == 5'h1E) size_lo[23:16] <= bus.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= '0;
        end else if (scan_dir && bus.valid && off == 5'h1F && entry_ok && !hit.hit) begin
            hit.hit           <= 1'b1;  // sticky until reset
            hit.first_cluster <= clus;
            hit.file_size     <= {bus.data, size_lo};
        end
    end

endmodule

/* hdl/fat_sequencer.sv */
/*
 * Reader FSM. Picks every sector to request, one at a time, tells each
 * consumer when the current read is its own and follows the FAT16 chain.
 */
`timescale 1ns/1ps
`include "fat_defs.svh"

module fat_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    sector_bus_if.sequencer       bus,
    input  logic                  is_boot,
    input  logic                  is_dbr,
    input  logic [31:0]           partition_sector,
    input  logic                  bpb_ok,
    input  fat_pkg::volume_info_t vol,
    input  fat_pkg::dir_hit_t     hit,
    output logic                  capture_boot,
    output logic                  scan_dir,
    output logic                  stream_data,
    output logic [31:0]           file_size,
    output fat_pkg::fat_state_t   fat_state,
    output logic                  busy
);

    function automatic logic chain_end(input logic [15:0] c);
        return (c >= `FAT16_EOC_MIN) || (c < 16'd2);
    endfunction

    fat_pkg::fat_state_t state;
    logic [31:0]         search_sector;  // raw lba during boot search
    logic [15:0]         sec_idx;        // sector within root or cluster
    logic [15:0]         cluster;
    logic [15:0]         fat_entry;
    logic                search_fat;     // current read is a fat sector
    logic                in_flight;
    logic                root_more;
    logic                clus_more;
    logic                go_done;

    assign fat_state    = state;
    assign busy         = (state != fat_pkg::IDLE) && (state != fat_pkg::DONE);
    assign capture_boot = (state == fat_pkg::SEARCH_MBR) || (state == fat_pkg::SEARCH_DBR);
    assign scan_dir     = (state == fat_pkg::LS_ROOT);
    assign stream_data  = (state == fat_pkg::READ_FILE) && !search_fat;

    assign root_more = (32'(sec_idx) + 32'd1) < 32'(vol.root_sector_count);
    assign clus_more = (32'(sec_idx) + 32'd1) < 32'(vol.cluster_size);

    always_comb begin
        case (state)
            fat_pkg::SEARCH_DBR: go_done = !(is_boot && is_dbr && bpb_ok);
            fat_pkg::LS_ROOT:    go_done = hit.hit ? chain_end(hit.first_cluster) : !root_more;
            fat_pkg::READ_FILE:  go_done = search_fat && chain_end(fat_entry);
            default:             go_done = 1'b0;
        endcase
    end

    // all terms only change on done, so sector holds across a read
    always_comb begin
        case (state)
            fat_pkg::LS_ROOT:   bus.sector = vol.root_sector + 32'(sec_idx);
            fat_pkg::READ_FILE: begin
                if (search_fat) begin
                    bus.sector = vol.first_fat_sector + 32'(cluster[15:8]);  // 256 entries/sector
                end else begin
                    bus.sector = vol.first_data_sector
                               + 32'(cluster) * 32'(vol.cluster_size) + 32'(sec_idx);
                end
            end
            default:            bus.sector = search_sector;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= fat_pkg::IDLE;
            bus.start     <= 1'b0;
            in_flight     <= 1'b0;
            search_sector <= '0;
            sec_idx       <= '0;
            cluster       <= '0;
            search_fat    <= 1'b0;
            file_size     <= '0;
        end else begin
            bus.start <= 1'b0;
            if (state == fat_pkg::IDLE) begin
                state <= fat_pkg::SEARCH_MBR;
            end else if (busy && !in_flight) begin
                bus.start <= 1'b1;  // first request only
                in_flight <= 1'b1;
            end else if (bus.done) begin
                case (state)
                    fat_pkg::SEARCH_MBR: begin
                        if (is_boot) begin
                            state <= fat_pkg::SEARCH_DBR;
                            if (!is_dbr) search_sector <= partition_sector;
                        end else begin
                            search_sector <= search_sector + 32'd1;
                        end
                    end
                    fat_pkg::SEARCH_DBR: begin
                        state   <= fat_pkg::LS_ROOT;
                        sec_idx <= '0;
                    end
                    fat_pkg::LS_ROOT: begin
                        if (hit.hit) begin
                            state      <= fat_pkg::READ_FILE;
                            cluster    <= hit.first_cluster;
                            sec_idx    <= '0;
                            search_fat <= 1'b0;
                            file_size  <= hit.file_size;
                        end else begin
                            sec_idx <= sec_idx + 16'd1;
                        end
                    end
                    fat_pkg::READ_FILE: begin
                        if (!search_fat) begin
                            if (clus_more) begin
                                sec_idx <= sec_idx + 16'd1;
                            end else begin
                                search_fat <= 1'b1;  // end of cluster, look up next
                                sec_idx    <= '0;
                            end
                        end else begin
                            search_fat <= 1'b0;
                            cluster    <= fat_entry;
                        end
                    end
                    default: ;
                endcase
                if (go_done) begin
                    state     <= fat_pkg::DONE;
                    in_flight <= 1'b0;
                end else begin
                    bus.start <= 1'b1;  // next read right after done
                end
            end
        end
    end

    // 2-byte entry at (cluster mod 256) * 2, little endian
    always_ff @(posedge clk) begin
        if (search_fat && bus.valid && bus.addr[8:1] == cluster[7:0]) begin
            fat_entry[8*bus.addr[0] +: 8] <= bus.data;
        end
    end

endmodule

/* hdl/file_streamer.sv */
/*
 * Forwards data-sector bytes to the output, one cycle later, until the
 * file size is reached. The tail of the last sector is dropped.
 */
`timescale 1ns/1ps

module file_streamer (
    input  logic           clk,
    input  logic           rst_n,
    sector_bus_if.observer bus,
    input  logic           stream_data,
    input  logic [31:0]    file_size,
    output logic           out_valid,
    output logic [7:0]     out_byte
);

    logic [31:0] byte_ptr;  // bytes emitted so far
    logic        take;

    assign take = stream_data && bus.valid && (byte_ptr < file_size);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_ptr  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
            if (take) byte_ptr <= byte_ptr + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) out_byte <= bus.data;
    end

endmodule

/* hdl/fat_reader_top.sv */
/*
 * FAT16 file reader top level. Requests sectors from an external block
 * device and streams the bytes of the file named by FILE_NAME.
 */
`timescale 1ns/1ps
`include "fat_defs.svh"

module fat_reader_top #(
    parameter logic [8*`NAME_LEN-1:0] FILE_NAME = "readme  txt"
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        rd_start,
    output logic [31:0] rd_sector,
    input  logic        rd_valid,
    input  logic [8:0]  rd_addr,
    input  logic [7:0]  rd_data,
    input  logic        rd_done,
    output logic        out_valid,
    output logic [7:0]  out_byte,
    output logic        file_found,
    output logic        busy,
    output logic [2:0]  fat_state
);

    sector_bus_if bus ();

    logic                  capture_boot;
    logic                  scan_dir;
    logic                  stream_data;
    logic                  is_boot;
    logic                  is_dbr;
    logic [31:0]           partition_sector;
    logic                  bpb_ok;
    fat_pkg::volume_info_t vol;
    fat_pkg::dir_hit_t     hit;
    logic [31:0]           file_size;

    assign rd_start   = bus.start;
    assign rd_sector  = bus.sector;
    assign bus.valid  = rd_valid;
    assign bus.addr   = rd_addr;
    assign bus.data   = rd_data;
    assign bus.done   = rd_done;
    assign file_found = hit.hit;

    volume_parser volume_parser_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus              (bus.observer),
        .capture_boot     (capture_boot),
        .sector_base      (bus.sector),
        .is_boot          (is_boot),
        .is_dbr           (is_dbr),
        .partition_sector (partition_sector),
        .bpb_ok           (bpb_ok),
        .vol              (vol)
    );

    dir_scanner #(
        .FILE_NAME (FILE_NAME)
    ) dir_scanner_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus.observer),
        .scan_dir (scan_dir),
        .hit      (hit)
    );

    fat_sequencer fat_sequencer_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus              (bus.sequencer),
        .is_boot          (is_boot),
        .is_dbr           (is_dbr),
        .partition_sector (partition_sector),
        .bpb_ok           (bpb_ok),
        .vol              (vol),
        .hit              (hit),
        .capture_boot     (capture_boot),
        .scan_dir         (scan_dir),
        .stream_data      (stream_data),
        .file_size        (file_size),
        .fat_state        (fat_state),
        .busy             (busy)
    );

    file_streamer file_streamer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus.observer),
        .stream_data (stream_data),
        .file_size   (file_size),
        .out_valid   (out_valid),
        .out_byte    (out_byte)
    );

endmodule

/* bench/tb_clock.sv */
/*
 * Free running testbench clock for the FAT16 reader bench.
 */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2  // 4 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

/* bench/sd_image_model.sv */
/*
 * Behavioral block device for the reader bench. Serves 512-byte sectors
 * from a byte-array disk image filled by the testbench, with idle gaps.
 */
`timescale 1ns/1ps

module sd_image_model #(
    parameter int SECTORS = 544
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_start,
    input  logic [31:0] rd_sector,
    output logic        rd_valid,
    output logic [8:0]  rd_addr,
    output logic [7:0]  rd_data,
    output logic        rd_done
);

    logic [7:0] disk [SECTORS*512];  // written by the image builders
    logic [1:0] gap_tab [512];       // idle cycles before each byte
    logic       bad_sector;          // request beyond the image

    // stream one sector, outputs change 1 ns after the clock edge
    task automatic serve_sector(input logic [31:0] sector);
        int base;
        if (sector >= 32'(SECTORS)) begin
            bad_sector = 1'b1;
        end
        base = int'(sector % 32'(SECTORS)) * 512;
        for (int i = 0; i < 512; i++) begin
            repeat (gap_tab[i]) begin
                @(posedge clk);
                #1;
            end
            rd_valid = 1'b1;
            rd_addr  = 9'(i);
            rd_data  = disk[base + i];
            @(posedge clk);
            #1;
            rd_valid = 1'b0;
        end
        rd_done = 1'b1;  // one cycle after the last byte
        @(posedge clk);
        #1;
        rd_done = 1'b0;
    endtask

    initial begin
        rd_valid   = 1'b0;
        rd_addr    = '0;
        rd_data    = '0;
        rd_done    = 1'b0;
        bad_sector = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            // next request may follow right after done
            while (rst_n && rd_start) begin
                serve_sector(rd_sector);
            end
        end
    end

endmodule

/* bench/fat_reader_props.sv */
/*
 * Sector port and output rules of the reader, bound to fat_reader_top.
 */
`timescale 1ns/1ps

module fat_reader_props (
    input logic        clk,
    input logic        rst_n,
    input logic        rd_start,
    input logic [31:0] rd_sector,
    input logic        rd_done,
    input logic        out_valid,
    input logic [2:0]  fat_state
);

    logic pending;  // a read is outstanding

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (rd_start) begin
            pending <= 1'b1;
        end else if (rd_done) begin
            pending <= 1'b0;
        end
    end

    sector_held: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> $stable(rd_sector))
        else $error("rd_sector changed while a read was outstanding");

    one_request: assert property (@(posedge clk) disable iff (!rst_n)
        rd_start |-> !pending)
        else $error("rd_start issued while a read was outstanding");

    quiet_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        (fat_state == 3'(fat_pkg::DONE)) |-> !out_valid)
        else $error("out_valid high in DONE");

endmodule

bind fat_reader_top fat_reader_props fat_reader_props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_start  (rd_start),
    .rd_sector (rd_sector),
    .rd_done   (rd_done),
    .out_valid (out_valid),
    .fat_state (fat_state)
);

/* bench/fat_reader_tb.sv */
/*
 * Directed tests for the FAT16 file reader. Builds disk images in the
 * block device model, runs the reader and checks the streamed bytes.
 */
`timescale 1ns/1ps

module fat_reader_tb;

    localparam int IMG_SECTORS = 544;
    localparam int SPC         = 2;  // sectors per cluster
    localparam int RESV        = 2;
    localparam int NFATS       = 2;
    localparam int SPF         = 2;  // sectors per FAT, 512 entries
    localparam int ROOT_ENTS   = 32;
    localparam int ROOT_SECS   = ROOT_ENTS * 32 / 512;
    localparam int CLUS_BYTES  = SPC * 512;
    localparam int WAIT_LIMIT  = 100000;

    logic        clk;
    logic        rst_n;
    logic        rd_start;
    logic [31:0] rd_sector;
    logic        rd_valid;
    logic [8:0]  rd_addr;
    logic [7:0]  rd_data;
    logic        rd_done;
    logic        out_valid;
    logic [7:0]  out_byte;
    logic        file_found;
    logic        busy;
    logic [2:0]  fat_state;

    logic [31:0] rng = 32'd9;
    logic [7:0]  got_q[$];
    logic [7:0]  exp_q[$];
    int          chain_q[$];  // file clusters in chain order

    tb_clock tb_clock_inst (
        .clk (clk)
    );

    sd_image_model #(
        .SECTORS (IMG_SECTORS)
    ) sd_image_model_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_start  (rd_start),
        .rd_sector (rd_sector),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_done   (rd_done)
    );

    fat_reader_top #(
        .FILE_NAME ("readme  txt")
    ) fat_reader_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_start   (rd_start),
        .rd_sector  (rd_sector),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_done    (rd_done),
        .out_valid  (out_valid),
        .out_byte   (out_byte),
        .file_found (file_found),
        .busy       (busy),
        .fat_state  (fat_state)
    );

    initial rst_n = 1'b0;

    always @(negedge clk) begin
        if (rst_n && out_valid) got_q.push_back(out_byte);  // mid-cycle, outputs stable
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // volume layout, cluster 2 is the first data cluster
    function automatic int fat_lba(input int base);
        return base + RESV;
    endfunction

    function automatic int root_lba(input int base);
        return fat_lba(base) + NFATS * SPF;
    endfunction

    function automatic int data_lba(input int base, input int clus);
        return root_lba(base) + ROOT_SECS + (clus - 2) * SPC;
    endfunction

    task automatic put_byte(input int addr, input logic [7:0] val);
        sd_image_model_inst.disk[addr] = val;
    endtask

    task automatic put_word(input int addr, input logic [31:0] val, input int len);
        for (int i = 0; i < len; i++) begin
            put_byte(addr + i, val[8*i +: 8]);  // little endian
        end
    endtask

    task automatic clear_image();
        for (int i = 0; i < IMG_SECTORS * 512; i++) begin
            sd_image_model_inst.disk[i] = 8'h00;
        end
        for (int i = 0; i < 512; i++) begin
            rng = xorshift32(rng);
            sd_image_model_inst.gap_tab[i] = 2'(rng % 3);
        end
    endtask

    task automatic write_mbr(input int part_lba);
        put_byte(0, 8'hFA);  // boot code, no jump
        put_word(16'h1C6, part_lba, 4);
        put_byte(16'h1FE, 8'h55);
        put_byte(16'h1FF, 8'hAA);
    endtask

    task automatic write_dbr(input int base, input int bps);
        int a;
        a = base * 512;
        put_byte(a, 8'hEB);
        put_byte(a + 1, 8'h3C);
        put_byte(a + 2, 8'h90);
        put_word(a + 11, bps, 2);
        put_byte(a + 13, 8'(SPC));
        put_word(a + 14, RESV, 2);
        put_byte(a + 16, 8'(NFATS));
        put_word(a + 17, ROOT_ENTS, 2);
        put_word(a + 22, SPF, 2);
        put_byte(a + 510, 8'h55);
        put_byte(a + 511, 8'hAA);
    endtask

    task automatic write_entry(input int base, input int idx, input logic [87:0] name,
                               input logic [7:0] attr, input int clus, input int size);
        int a;
        a = root_lba(base) * 512 + idx * 32;
        for (int i = 0; i < 11; i++) begin
            put_byte(a + i, name[8*(10-i) +: 8]);
        end
        put_byte(a + 11, attr);
        put_word(a + 26, clus, 2);
        put_word(a + 28, size, 4);
    endtask

    task automatic set_fat(input int base, input int clus, input int next);
        for (int f = 0; f < NFATS; f++) begin
            put_word((fat_lba(base) + f * SPF) * 512 + clus * 2, next, 2);
        end
    endtask

    // link chain_q in the FAT, fill its clusters and build the expected stream
    task automatic build_file(input int base, input int size);
        int next;
        int a;
        for (int k = 0; k < chain_q.size(); k++) begin
            if (k == chain_q.size() - 1) begin
                next = 32'hFFFF;
            end else begin
                next = chain_q[k + 1];
            end
            set_fat(base, chain_q[k], next);
            for (int i = 0; i < CLUS_BYTES; i++) begin
                rng = xorshift32(rng);
                put_byte(data_lba(base, chain_q[k]) * 512 + i, rng[7:0]);
            end
        end
        exp_q.delete();
        for (int n = 0; n < size; n++) begin
            a = data_lba(base, chain_q[n / CLUS_BYTES]) * 512 + n % CLUS_BYTES;
            exp_q.push_back(sd_image_model_inst.disk[a]);
        end
    endtask

    task automatic reset_dut();
        int cycles;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        check_value("rd_start in reset", 32'(rd_start), 0);
        check_value("out_valid in reset", 32'(out_valid), 0);
        check_value("file_found in reset", 32'(file_found), 0);
        check_value("busy in reset", 32'(busy), 0);
        check_value("fat_state in reset", 32'(fat_state), 32'(fat_pkg::IDLE));
        got_q.delete();
        rst_n  = 1'b1;
        cycles = 0;
        while (!rd_start) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 10) begin
                $display("no sector request within 10 cycles after reset");
                stop_on_error();
            end
        end
        check_value("cycles from reset to first rd_start", cycles, 2);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (fat_state != 3'(fat_pkg::DONE)) begin
            @(negedge clk);
            cycles++;
            if (sd_image_model_inst.bad_sector) begin
                $display("the reader asked for a sector outside the disk image");
                stop_on_error();
            end
            if (cycles > WAIT_LIMIT) begin
                $display("timeout, the reader did not reach DONE in %0d cycles", WAIT_LIMIT);
                stop_on_error();
            end
        end
    endtask

    task automatic check_result(input logic exp_found);
        check_value("busy at DONE", 32'(busy), 0);
        check_value("file_found", 32'(file_found), 32'(exp_found));
        check_value("number of output bytes", got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value($sformatf("output byte %0d", i), 32'(got_q[i]), 32'(exp_q[i]));
        end
    endtask

    task automatic test_mbr_single_cluster();
        clear_image();
        write_mbr(8);
        write_dbr(8, 512);
        write_entry(8, 0, "OTHER   BIN", 8'h20, 9, 100);
        write_entry(8, 17, "README  TXT", 8'h20, 5, 700);  // second root sector
        chain_q.delete();
        chain_q.push_back(5);
        build_file(8, 700);
        reset_dut();
        wait_done();
        check_result(1'b1);
    endtask

    task automatic test_fragmented_file();
        clear_image();
        write_mbr(8);
        write_dbr(8, 512);
        write_entry(8, 0, "NOTES   TXT", 8'h20, 4, 10);
        write_entry(8, 1, "README  TXT", 8'h20, 3, 2348);
        chain_q.delete();
        chain_q.push_back(3);
        chain_q.push_back(260);  // entry lives in the second FAT sector
        chain_q.push_back(7);
        build_file(8, 2348);
        reset_dut();
        wait_done();
        check_result(1'b1);
    endtask

    task automatic test_name_absent();
        clear_image();
        write_mbr(8);
        write_dbr(8, 512);
        write_entry(8, 0, "README  TXT", 8'h08, 0, 0);  // volume label
        write_entry(8, 1, "README  TXT", 8'h20, 5, 700);
        put_byte(root_lba(8) * 512 + 32, 8'hE5);  // deleted
        write_entry(8, 2, "NOTES   TXT", 8'h20, 6, 50);
        write_entry(8, 20, "README  DOC", 8'h20, 7, 80);
        exp_q.delete();
        reset_dut();
        wait_done();
        check_result(1'b0);
    endtask

    task automatic test_forward_search();
        clear_image();
        write_dbr(3, 512);
        write_entry(3, 4, "README  TXT", 8'h20, 2, 513);
        chain_q.delete();
        chain_q.push_back(2);
        build_file(3, 513);
        reset_dut();
        wait_done();
        check_result(1'b1);
    endtask

    task automatic test_bad_sector_size();
        clear_image();
        write_mbr(8);
        write_dbr(8, 1024);
        write_entry(8, 0, "README  TXT", 8'h20, 5, 700);
        chain_q.delete();
        chain_q.push_back(5);
        build_file(8, 700);
        exp_q.delete();  // nothing may come out
        reset_dut();
        wait_done();
        check_result(1'b0);
    endtask

    initial begin
        test_mbr_single_cluster();
        test_fragmented_file();
        test_name_absent();
        test_forward_search();
        test_bad_sector_size();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* fat_reader_top.f */
+incdir+common
common/fat_pkg.sv
common/sector_bus_if.sv
hdl/volume_parser.sv
hdl/dir_scanner.sv
hdl/fat_sequencer.sv
hdl/file_streamer.sv
hdl/fat_reader_top.sv
bench/tb_clock.sv
bench/sd_image_model.sv
bench/fat_reader_props.sv
bench/fat_reader_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the reader testbench with Verilator and run it.
# The exit status is nonzero when the build or any check fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module fat_reader_tb \
    -f fat_reader_top.f -o fat_reader_sim &&
./obj_dir/fat_reader_sim ||
{ echo "simulation build or run failed"; exit 1; }
